//--- verilog/uartPkg.sv
/*
 * Shared definitions for the SC2661-style UART
 *   character width, register addresses, operating-mode codes,
 *   status bit indexes and the command word union
 */

`default_nettype none

package uartPkg;

  localparam int dataWidth = 8;           // Character and register width

  // Register addresses ---------------------------------------------------
  localparam logic [1:0] addrThr     = 2'd0;  // Write THR, read RHR
  localparam logic [1:0] addrStatus  = 2'd1;  // Status, SYN/DLE writes ignored
  localparam logic [1:0] addrMode    = 2'd2;  // Mode register not kept
  localparam logic [1:0] addrCommand = 2'd3;

  // Operating modes, codes 01 and 11 act as normal
  localparam logic [1:0] opNormal    = 2'b00;
  localparam logic [1:0] opLocalLoop = 2'b10;

  // Status bit indexes
  localparam int srTxRdy   = 0;           // THR ready
  localparam int srRxRdy   = 1;           // RHR full
  localparam int srTxEmt   = 2;           // Frame finished, cleared by status read
  localparam int srOverrun = 4;

  // Command register fields, declared MSB first so txEnable lands on bit 0
  typedef struct packed {
    logic [1:0] opMode;                   // Bits 7:6
    logic       rtsForce;                 // 1 drives rtsN low
    logic       errorClear;               // 1 clears overrun on write
    logic       breakUnused;              // Force break, not implemented
    logic       rxEnable;
    logic       dtrForce;                 // 1 drives dtrN low
    logic       txEnable;
  } commandFields_s;

  // Written by the CPU as a byte, decoded as fields
  typedef union packed {
    logic [dataWidth-1:0] raw;
    commandFields_s       f;
  } commandWord_u;

endpackage

`default_nettype wire

//--- verilog/uartRegFile.sv
/*
 * CPU bus side of the UART
 *   chip-enable access decode, one execution per ceN assertion
 *   command, status, holding registers and read latch
 *   four-phase request to the transmitter, loopback select
 */

`default_nettype none

module uartRegFile (
  input  logic                          uart_sysclk,
  input  logic                          cmd_resetError,
  input  logic                          ceN,
  input  logic                          readN,
  input  logic [1:0]                    address,
  input  logic [uartPkg::dataWidth-1:0] dataIn,
  output logic [uartPkg::dataWidth-1:0] dataOut,
  output logic                          txReq,
  output logic [uartPkg::dataWidth-1:0] txData,      // THR toward the transmitter
  input  logic                          txAck,
  output logic                          txEnable,
  output logic                          rxEnable,
  input  logic                          txd,
  input  logic                          rxd,
  output logic                          serialIn,    // Receiver input after loopback mux
  input  logic                          rxValid,
  input  logic [uartPkg::dataWidth-1:0] rxData,
  output logic                          txRdyN,
  output logic                          rxRdyN,
  output logic                          txEmtN,
  output logic                          dtrN,
  output logic                          rtsN
);

  uartPkg::commandWord_u command;         // Command register
  uartPkg::commandWord_u writeCmd;        // Bus data seen as a command word

  logic [uartPkg::dataWidth-1:0] status;
  logic [uartPkg::dataWidth-1:0] rxHold;    // Receive holding register
  logic [uartPkg::dataWidth-1:0] readLatch; // Value shown on dataOut
  logic [uartPkg::dataWidth-1:0] pendByte;  // THR write that arrived mid-frame
  logic                          pendValid;
  logic                          accessDone; // Access already executed for this ceN
  logic                          doAccess;
  logic                          txBusy;

  assign writeCmd = uartPkg::commandWord_u'(dataIn);
  assign doAccess = !ceN && !accessDone;
  assign txBusy   = txReq || txAck;       // Handshake not back to rest

  // Register update ------------------------------------------------------
  always_ff @(posedge uart_sysclk) begin
    if (cmd_resetError) begin
      command.raw <= '0;
      status      <= 8'h01;               // Only THR ready
      readLatch   <= '0;
      txReq       <= 1'b0;
      pendValid   <= 1'b0;
      accessDone  <= 1'b0;
    end else begin
      accessDone <= !ceN;                 // Rearm once ceN goes high

      // Transmit handshake
      if (!txEnable) begin
        txReq           <= 1'b0;          // Transmitter is forced idle
        status[uartPkg::srTxRdy] <= 1'b1;
      end else if (txReq && txAck) begin
        txReq           <= 1'b0;          // Frame done, second phase
        status[uartPkg::srTxRdy] <= 1'b1;
      end else if (pendValid && !txBusy) begin
        txData    <= pendByte;            // Late write lands once ack has fallen
        pendValid <= 1'b0;
      end

      // Bus access
      if (doAccess) begin
        if (!readN) begin
          case (address)
            uartPkg::addrThr:     readLatch <= rxHold;
            uartPkg::addrStatus:  readLatch <= status;
            uartPkg::addrCommand: readLatch <= command.raw;
            default:              readLatch <= '0;   // No mode register
          endcase
          if (address == uartPkg::addrThr)
            status[uartPkg::srRxRdy] <= 1'b0;       // RHR taken
          if (address == uartPkg::addrStatus)
            status[uartPkg::srTxEmt] <= 1'b0;
        end else begin
          case (address)
            uartPkg::addrThr: begin
              if (txBusy) begin
                pendByte  <= dataIn;      // Keep txData stable during the frame
                pendValid <= 1'b1;
              end else begin
                txData <= dataIn;
                if (txEnable) begin
                  txReq <= 1'b1;          // First phase
                  status[uartPkg::srTxRdy] <= 1'b0;
                end
              end
            end
            uartPkg::addrCommand: begin
              command.raw <= dataIn;
              if (!writeCmd.f.rxEnable)
                status[uartPkg::srRxRdy] <= 1'b0;
              if (writeCmd.f.errorClear)
                status[uartPkg::srOverrun] <= 1'b0;
            end
            default: ;                    // SYN/DLE and mode writes dropped
          endcase
        end
      end

      // Completion flags win over clears from the bus
      if (txEnable && txReq && txAck)
        status[uartPkg::srTxEmt] <= 1'b1;
      if (rxValid) begin
        rxHold <= rxData;                 // Newest byte overwrites
        status[uartPkg::srRxRdy] <= 1'b1;
        if (status[uartPkg::srRxRdy])
          status[uartPkg::srOverrun] <= 1'b1; // Previous byte never read
      end
    end
  end

  // Outputs --------------------------------------------------------------
  assign dataOut  = (!ceN && !readN) ? readLatch : '0;
  assign txEnable = command.f.txEnable;
  assign rxEnable = command.f.rxEnable;
  assign txRdyN   = txEnable ? ~status[uartPkg::srTxRdy] : 1'b1;
  assign rxRdyN   = rxEnable ? ~status[uartPkg::srRxRdy] : 1'b1;
  assign txEmtN   = ~status[uartPkg::srTxEmt];
  assign dtrN     = ~command.f.dtrForce;
  assign rtsN     = ~command.f.rtsForce;

  // Local loopback feeds the receiver from our own txd
  always_comb begin
    case (command.f.opMode)
      uartPkg::opLocalLoop: serialIn = txd;
      uartPkg::opNormal:    serialIn = rxd;
      default:              serialIn = rxd;  // Remote loop not kept
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/uartTx.sv
/*
 * 8N1 transmitter
 *   idle, start, data, stop, done FSM with bit timer
 *   ack side of the four-phase handshake
 */

`default_nettype none

module uartTx #(
  parameter int bitPeriod = 16            // System clocks per bit
) (
  input  logic                          uart_sysclk,
  input  logic                          cmd_resetError,
  input  logic                          txEnable,
  input  logic                          txReq,
  input  logic [uartPkg::dataWidth-1:0] txData,
  output logic                          txAck,
  output logic                          txd
);

  localparam int timerWidth = $clog2(bitPeriod);
  localparam logic [timerWidth-1:0] lastTick = timerWidth'(bitPeriod - 1);
  localparam logic [2:0] lastBit = 3'(uartPkg::dataWidth - 1);

  localparam logic [2:0] stIdle  = 3'd0;
  localparam logic [2:0] stStart = 3'd1;
  localparam logic [2:0] stData  = 3'd2;
  localparam logic [2:0] stStop  = 3'd3;
  localparam logic [2:0] stDone  = 3'd4;  // Holding ack until req drops

  logic [2:0]            state;
  logic [timerWidth-1:0] bitTimer;
  logic [2:0]            bitIdx;
  logic                  bitEnd;

  assign bitEnd = (bitTimer == lastTick);

  always_ff @(posedge uart_sysclk) begin
    if (cmd_resetError || !txEnable) begin // Disable behaves like reset
      state    <= stIdle;
      bitTimer <= '0;
      bitIdx   <= '0;
      txd      <= 1'b1;                   // Mark
      txAck    <= 1'b0;
    end else begin
      // Timer runs only while a bit is on the line
      if (state == stStart || state == stData || state == stStop)
        bitTimer <= bitEnd ? '0 : bitTimer + 1'b1;

      case (state)
        stIdle: begin
          if (txReq) begin
            state <= stStart;
            txd   <= 1'b0;                // Start bit
          end
        end
        stStart: begin
          if (bitEnd) begin
            state  <= stData;
            bitIdx <= '0;
            txd    <= txData[0];          // LSB first
          end
        end
        stData: begin
          if (bitEnd) begin
            if (bitIdx == lastBit) begin
              state <= stStop;
              txd   <= 1'b1;
            end else begin
              bitIdx <= bitIdx + 3'd1;
              txd    <= txData[bitIdx + 3'd1];
            end
          end
        end
        stStop: begin
          if (bitEnd) begin
            state <= stDone;
            txAck <= 1'b1;                // Frame complete
          end
        end
        stDone: begin
          if (!txReq) begin
            txAck <= 1'b0;                // Last phase, back to rest
            state <= stIdle;
          end
        end
        default: state <= stIdle;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog/uartRx.sv
/*
 * 8N1 receiver
 *   start detect, half-bit wait, mid-bit sampling into a right shift register
 *   stop bit timing and one-cycle rxValid pulse
 */

`default_nettype none

module uartRx #(
  parameter int bitPeriod = 16            // System clocks per bit, even
) (
  input  logic                          uart_sysclk,
  input  logic                          cmd_resetError,
  input  logic                          rxEnable,
  input  logic                          serialIn,
  output logic                          rxValid,
  output logic [uartPkg::dataWidth-1:0] rxData
);

  localparam int timerWidth = $clog2(bitPeriod);
  localparam logic [timerWidth-1:0] lastTick = timerWidth'(bitPeriod - 1);
  localparam logic [timerWidth-1:0] halfTick = timerWidth'(bitPeriod / 2 - 1);
  localparam logic [2:0] lastBit = 3'(uartPkg::dataWidth - 1);

  localparam logic [1:0] stIdle = 2'd0;
  localparam logic [1:0] stHalf = 2'd1;   // Wait to middle of start bit
  localparam logic [1:0] stData = 2'd2;
  localparam logic [1:0] stStop = 2'd3;

  logic [1:0]            state;
  logic [timerWidth-1:0] bitTimer;
  logic [2:0]            bitIdx;
  logic                  bitEnd;

  assign bitEnd = (bitTimer == lastTick);

  always_ff @(posedge uart_sysclk) begin
    if (cmd_resetError || !rxEnable) begin
      state    <= stIdle;
      bitTimer <= '0;
      bitIdx   <= '0;
      rxValid  <= 1'b0;
    end else begin
      rxValid <= 1'b0;                    // Single-cycle pulse
      case (state)
        stIdle: begin
          bitTimer <= '0;
          if (!serialIn)
            state <= stHalf;              // Falling edge seen
        end
        stHalf: begin
          if (bitTimer == halfTick) begin
            bitTimer <= '0;
            bitIdx   <= '0;
            // Line back high mid start bit counts as a glitch
            state    <= serialIn ? stIdle : stData;
          end else begin
            bitTimer <= bitTimer + 1'b1;
          end
        end
        stData: begin
          if (bitEnd) begin
            bitTimer <= '0;
            rxData   <= {serialIn, rxData[uartPkg::dataWidth-1:1]}; // LSB arrives first
            bitIdx   <= bitIdx + 3'd1;
            if (bitIdx == lastBit)
              state <= stStop;
          end else begin
            bitTimer <= bitTimer + 1'b1;
          end
        end
        stStop: begin
          if (bitEnd) begin
            bitTimer <= '0;
            rxValid  <= 1'b1;             // Mid stop bit, byte complete
            state    <= stIdle;
          end else begin
            bitTimer <= bitTimer + 1'b1;
          end
        end
        default: state <= stIdle;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog/sc2661Uart.sv
/*
 * SC2661-style UART top level
 *   register file, transmitter and receiver
 */

`default_nettype none

module sc2661Uart #(
  parameter int bitPeriod = 16            // Even, at least 4
) (
  input  logic                          uart_sysclk,
  input  logic                          cmd_resetError,
  input  logic                          ceN,
  input  logic                          readN,
  input  logic [1:0]                    address,
  input  logic [uartPkg::dataWidth-1:0] dataIn,
  input  logic                          rxd,
  output logic [uartPkg::dataWidth-1:0] dataOut,
  output logic                          txd,
  output logic                          txRdyN,
  output logic                          rxRdyN,
  output logic                          txEmtN,
  output logic                          dtrN,
  output logic                          rtsN
);

  logic                          txReq;
  logic                          txAck;
  logic [uartPkg::dataWidth-1:0] txData;
  logic                          txEnable;
  logic                          rxEnable;
  logic                          serialIn;  // Receiver input after loopback mux
  logic                          rxValid;
  logic [uartPkg::dataWidth-1:0] rxData;

  uartRegFile regFile0 (
    .uart_sysclk    (uart_sysclk),
    .cmd_resetError (cmd_resetError),
    .ceN            (ceN),
    .readN          (readN),
    .address        (address),
    .dataIn         (dataIn),
    .dataOut        (dataOut),
    .txReq          (txReq),
    .txData         (txData),
    .txAck          (txAck),
    .txEnable       (txEnable),
    .rxEnable       (rxEnable),
    .txd            (txd),
    .rxd            (rxd),
    .serialIn       (serialIn),
    .rxValid        (rxValid),
    .rxData         (rxData),
    .txRdyN         (txRdyN),
    .rxRdyN         (rxRdyN),
    .txEmtN         (txEmtN),
    .dtrN           (dtrN),
    .rtsN           (rtsN)
  );

  uartTx #(.bitPeriod(bitPeriod)) tx0 (
    .uart_sysclk    (uart_sysclk),
    .cmd_resetError (cmd_resetError),
    .txEnable       (txEnable),
    .txReq          (txReq),
    .txData         (txData),
    .txAck          (txAck),
    .txd            (txd)
  );

  uartRx #(.bitPeriod(bitPeriod)) rx0 (
    .uart_sysclk    (uart_sysclk),
    .cmd_resetError (cmd_resetError),
    .rxEnable       (rxEnable),
    .serialIn       (serialIn),
    .rxValid        (rxValid),
    .rxData         (rxData)
  );

endmodule

`default_nettype wire

//--- tb/uartChecks_assert.sv
/*
 * Concurrent checks on the UART register file
 *   four-phase handshake with the transmitter
 *   txd at mark while disabled, one execution per held read
 */

`default_nettype none

module uartChecks (
  input logic                          uart_sysclk,
  input logic                          cmd_resetError,
  input logic                          ceN,
  input logic                          readN,
  input logic [uartPkg::dataWidth-1:0] dataOut,
  input logic                          txReq,
  input logic                          txAck,
  input logic                          txd,
  input uartPkg::commandWord_u         command   // Decoded view gives txEnable
);

  int failCount = 0;                      // Read by the testbench at the end

  // Request held until the transmitter acks
  reqHeld: assert property (@(posedge uart_sysclk) disable iff (cmd_resetError)
      txReq && !txAck && command.f.txEnable |=> txReq)
    else begin
      $error("txReq dropped before txAck rose");
      failCount++;
    end

  // Ack held until the request is gone
  ackHeld: assert property (@(posedge uart_sysclk) disable iff (cmd_resetError)
      txAck && txReq && command.f.txEnable |=> txAck)
    else begin
      $error("txAck fell while txReq was still high");
      failCount++;
    end

  // Disabled transmitter sits at mark
  txdMark: assert property (@(posedge uart_sysclk) disable iff (cmd_resetError)
      !command.f.txEnable |=> txd)
    else begin
      $error("txd low while the transmitter is disabled");
      failCount++;
    end

  // A held read latches once per ceN, so dataOut stays put
  readOnce: assert property (@(posedge uart_sysclk) disable iff (cmd_resetError)
      !ceN && !readN && $past(!ceN && !readN) |=> ceN || readN || $stable(dataOut))
    else begin
      $error("dataOut changed while a read was held");
      failCount++;
    end

endmodule

`default_nettype wire

//--- tb/tbUart.sv
/*
 * Testbench for the SC2661-style UART
 *   clock, reset, CPU bus tasks, serial frame driver and catcher
 *   reset, command, transmit, receive, overrun and loopback tests
 *   watchdog and closing report
 */

`default_nettype none

module tbUart;

  localparam int bitPeriod      = 16;
  localparam int clkPeriod      = 100;
  localparam int watchdogCycles = 8 * 10 * bitPeriod * 2 + 2000;

  logic       uart_sysclk = 1'b0;
  logic       cmd_resetError = 1'b1;     // Held from time zero
  logic       ceN = 1'b1;
  logic       readN = 1'b1;
  logic [1:0] address = 2'd0;
  logic [7:0] dataIn = 8'h00;
  logic       rxd = 1'b1;                 // Line idles at mark
  logic [7:0] dataOut;
  logic       txd, txRdyN, rxRdyN, txEmtN, dtrN, rtsN;

  int          errCount = 0;
  int          bindFails;
  logic [31:0] rngState = 32'h0a81_d285;
  logic [7:0]  got, txByte, rxByte, firstByte, secondByte, cmdByte;

  sc2661Uart #(.bitPeriod(bitPeriod)) dut0 (
    .uart_sysclk(uart_sysclk), .cmd_resetError(cmd_resetError), .ceN(ceN), .readN(readN),
    .address(address), .dataIn(dataIn), .rxd(rxd), .dataOut(dataOut), .txd(txd),
    .txRdyN(txRdyN), .rxRdyN(rxRdyN), .txEmtN(txEmtN), .dtrN(dtrN), .rtsN(rtsN)
  );

  bind uartRegFile uartChecks checks0 (
    .uart_sysclk(uart_sysclk), .cmd_resetError(cmd_resetError), .ceN(ceN),
    .readN(readN), .dataOut(dataOut), .txReq(txReq), .txAck(txAck), .txd(txd),
    .command(command)
  );

  always #(clkPeriod / 2) uart_sysclk = ~uart_sysclk;

  // Helpers ---------------------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [7:0] nextByte();
    rngState = xorshift32(rngState);
    return rngState[7:0];
  endfunction

  task automatic checkValue(input string what, input logic [7:0] value, input logic [7:0] exp);
    assert (value === exp) else begin
      $display("ERR %0t: %s is %h, expected %h", $time, what, value, exp);
      errCount++;
    end
  endtask

  task automatic checkBit(input string what, input logic value, input logic exp);
    assert (value === exp) else begin
      $display("ERR %0t: %s is %b, expected %b", $time, what, value, exp);
      errCount++;
    end
  endtask

  task automatic busWrite(input logic [1:0] addr, input logic [7:0] data);
    @(negedge uart_sysclk);
    ceN     = 1'b0;                       // Executes on the next edge
    readN   = 1'b1;
    address = addr;
    dataIn  = data;
    repeat (2) @(negedge uart_sysclk);
    ceN = 1'b1;
  endtask

  task automatic busRead(input logic [1:0] addr, output logic [7:0] data);
    @(negedge uart_sysclk);
    ceN     = 1'b0;
    readN   = 1'b0;
    address = addr;
    repeat (3) @(negedge uart_sysclk);
    data  = dataOut;                      // Latch settled by now
    ceN   = 1'b1;
    readN = 1'b1;
  endtask

  // 8N1 frame on rxd, LSB first
  task automatic sendFrame(input logic [7:0] data);
    @(negedge uart_sysclk);
    rxd = 1'b0;
    repeat (bitPeriod) @(negedge uart_sysclk);
    for (int i = 0; i < 8; i++) begin
      rxd = data[i];
      repeat (bitPeriod) @(negedge uart_sysclk);
    end
    rxd = 1'b1;                           // Stop bit
    repeat (bitPeriod) @(negedge uart_sysclk);
  endtask

  // Returns at mid stop bit
  task automatic catchFrame(output logic [7:0] data);
    logic startBit;
    logic stopBit;
    wait (txd == 1'b0);
    repeat (bitPeriod / 2) @(negedge uart_sysclk);
    startBit = txd;
    for (int i = 0; i < 8; i++) begin
      repeat (bitPeriod) @(negedge uart_sysclk);
      data[i] = txd;
    end
    repeat (bitPeriod) @(negedge uart_sysclk);
    stopBit = txd;
    checkBit("start bit", startBit, 1'b0);
    checkBit("stop bit", stopBit, 1'b1);
  endtask

  // Tests -----------------------------------------------------------------
  initial begin
    repeat (16) @(negedge uart_sysclk);
    cmd_resetError = 1'b0;

    checkValue("reset outputs", {2'b0, txd, txRdyN, rxRdyN, txEmtN, dtrN, rtsN}, 8'h3f);
    busRead(uartPkg::addrStatus, got);
    checkValue("reset status", got, 8'h01);
    busRead(uartPkg::addrCommand, got);
    checkValue("reset command", got, 8'h00);

    // Command readback and modem control pins
    for (int i = 0; i < 3; i++) begin
      cmdByte = (i == 1) ? 8'h22 : nextByte();
      busWrite(uartPkg::addrCommand, cmdByte);
      checkBit("dtrN", dtrN, ~cmdByte[1]);
      checkBit("rtsN", rtsN, ~cmdByte[5]);
      busRead(uartPkg::addrCommand, got);
      checkValue("command readback", got, cmdByte);
    end

    // Transmit one byte
    busWrite(uartPkg::addrCommand, 8'h01);
    checkBit("txRdyN idle", txRdyN, 1'b0);
    txByte = nextByte();
    fork
      busWrite(uartPkg::addrThr, txByte);
      catchFrame(got);
    join
    checkValue("txd frame", got, txByte);
    checkBit("txRdyN busy", txRdyN, 1'b1);
    wait (txRdyN == 1'b0);
    @(negedge uart_sysclk);
    checkBit("txEmtN done", txEmtN, 1'b0);
    busRead(uartPkg::addrStatus, got);
    checkValue("status after frame", got, 8'h05);
    busRead(uartPkg::addrStatus, got);
    checkValue("status second read", got, 8'h01);
    checkBit("txEmtN cleared", txEmtN, 1'b1);

    // Receive one byte
    busWrite(uartPkg::addrCommand, 8'h04);
    rxByte = nextByte();
    sendFrame(rxByte);
    wait (rxRdyN == 1'b0);
    busRead(uartPkg::addrThr, got);
    checkValue("rx byte", got, rxByte);
    checkBit("rxRdyN after read", rxRdyN, 1'b1);

    // Two frames, no read in between
    firstByte  = nextByte();
    secondByte = nextByte();
    sendFrame(firstByte);
    sendFrame(secondByte);
    wait (rxRdyN == 1'b0);
    busRead(uartPkg::addrStatus, got);
    checkValue("overrun status", got, 8'h13);
    busRead(uartPkg::addrThr, got);
    checkValue("overrun byte", got, secondByte);
    busWrite(uartPkg::addrCommand, 8'h14);  // rxEnable with errorClear
    busRead(uartPkg::addrStatus, got);
    checkValue("status after clear", got, 8'h01);

    // Local loopback, rxd held low to show it is ignored
    busWrite(uartPkg::addrCommand, 8'h85);
    @(negedge uart_sysclk);
    rxd    = 1'b0;
    txByte = nextByte();
    busWrite(uartPkg::addrThr, txByte);
    wait (rxRdyN == 1'b0);
    busRead(uartPkg::addrThr, got);
    checkValue("loopback byte", got, txByte);
    rxd = 1'b1;

    repeat (4) @(negedge uart_sysclk);
    bindFails = dut0.regFile0.checks0.failCount;
    $display("checks done: %0d value errors, %0d assertion errors", errCount, bindFails);
    if (errCount == 0 && bindFails == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Watchdog --------------------------------------------------------------
  initial begin
    #(watchdogCycles * clkPeriod);
    $display("timeout: the run did not finish within %0d cycles", watchdogCycles);
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
verilog/uartPkg.sv
verilog/uartRegFile.sv
verilog/uartTx.sv
verilog/uartRx.sv
verilog/sc2661Uart.sv
tb/uartChecks_assert.sv
tb/tbUart.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --assert -j 0
TOP      = tbUart
FILELIST = src.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: simulate clean

simulate:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) +verilator+error+limit+100 > $(LOG) 2>&1; \
	status=$$?; cat $(LOG); \
	if grep -q "test failed" $(LOG) || [ $$status -ne 0 ]; then exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)
